//--- cache_system.f
+incdir+tb
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_replace.sv
verilog/cache_ctrl.sv
verilog/main_memory.sv
verilog/cache_system.sv
tb/tb_cache_system.sv

//--- Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP ?= tb_cache_system
FILELIST ?= cache_system.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_cache_ref.svh
`ifndef TB_CACHE_REF_SVH
`define TB_CACHE_REF_SVH

// Byte image of the backing store
logic [7:0] image [MEM_LINES*LINE_BYTES];

// Lines the cache should hold, per way and index
logic ref_valid [WAYS][LINES];
logic [27:0] ref_line_no [WAYS][LINES];
int ref_rr [LINES];

function automatic void init_reference();
	logic [31:0] word_addr;
	for (int a = 0; a < MEM_LINES * LINE_BYTES; a++) begin
		word_addr = 32'(a) & ~32'h3; // Each word holds its own address
		image[a] = word_addr[8*(a%4) +: 8];
	end
	for (int i = 0; i < LINES; i++) begin
		ref_rr[i] = 0;
		for (int w = 0; w < WAYS; w++)
			ref_valid[w][i] = 1'b0;
	end
endfunction

function automatic logic [LINE_BITS-1:0] expected_line(input logic [31:0] addr);
	logic [LINE_BITS-1:0] line;
	int base;
	base = (int'(addr[31:4]) % MEM_LINES) * LINE_BYTES;
	for (int b = 0; b < LINE_BYTES; b++)
		line[8*b +: 8] = image[base + b];
	return line;
endfunction

function automatic void apply_write(input logic [31:0] addr, input logic [15:0] be,
		input logic [LINE_BITS-1:0] data);
	int base;
	base = (int'(addr[31:4]) % MEM_LINES) * LINE_BYTES;
	for (int b = 0; b < LINE_BYTES; b++) begin
		if (be[b])
			image[base + b] = data[8*b +: 8];
	end
endfunction

// Hit or miss for this access, then allocate on a miss
function automatic logic predict_hit(input logic [31:0] addr);
	logic [27:0] line_no;
	int idx;
	int way;
	line_no = addr[31:4];
	idx = int'(line_no) % LINES;
	for (int w = 0; w < WAYS; w++) begin
		if (ref_valid[w][idx] && ref_line_no[w][idx] == line_no)
			return 1'b1;
	end
	way = ref_rr[idx];
	for (int w = WAYS - 1; w >= 0; w--) begin
		if (!ref_valid[w][idx])
			way = w; // Lowest invalid way first
	end
	ref_valid[way][idx] = 1'b1;
	ref_line_no[way][idx] = line_no;
	ref_rr[idx] = (ref_rr[idx] + 1) % WAYS; // Pointer moves on every refill
	return 1'b0;
endfunction

`endif

//--- tb/tb_cache_system.sv
`timescale 1ns/10ps

module tb_cache_system;
	import cache_pkg::*;

	localparam int WAYS = 2;
	localparam int LINES = 4;
	localparam int MEM_LINES = 64;
	localparam int MEM_LATENCY = 3;
	localparam int TIMEOUT = 100; // Cycles per wait

	typedef struct packed {
		logic is_read;
		logic [LINE_BITS-1:0] data;
		logic hit;
		logic [31:0] accept_cycle;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	cpu_req_t req;
	logic req_ready;
	logic resp_valid;
	cpu_resp_t resp;

	int seed = 7;
	logic [31:0] cycle = '0;
	expect_t exp_q[$]; // Accepted accesses still waiting for resp
	expect_t got_exp;

	`include "tb_cache_ref.svh"

	cache_system #(
		.WAYS(WAYS), .LINES(LINES), .MEM_LINES(MEM_LINES), .MEM_LATENCY(MEM_LATENCY)
	) cache_system_inst (
		.clk, .reset, .req_valid, .req, .req_ready, .resp_valid, .resp
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input logic [LINE_BITS-1:0] got,
			input logic [LINE_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s at %0t", TIMEOUT, what, $time);
		stop_with_failure();
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [LINE_BITS-1:0] random_line();
		return {rand_word(), rand_word(), rand_word(), rand_word()};
	endfunction

	// Returns on the edge where req_ready was high
	task automatic wait_for_ready();
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT)
				report_timeout("req_ready");
		end while (!req_ready);
	endtask

	task automatic do_access(input logic [31:0] addr, input op_t op,
			input logic [15:0] be, input logic [LINE_BITS-1:0] data);
		cpu_req_t r;
		expect_t e;
		int waited;
		r.addr = addr;
		r.op = op;
		r.byte_en = be;
		r.wdata = data;
		req <= r;
		req_valid <= 1'b1;
		wait_for_ready(); // Accept edge
		req_valid <= 1'b0;
		e.is_read = (op == OP_READ);
		e.data = expected_line(addr); // Image before this write lands
		e.hit = predict_hit(addr);
		e.accept_cycle = cycle;
		exp_q.push_back(e);
		if (op == OP_WRITE)
			apply_write(addr, be, data);
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT)
				report_timeout("resp_valid");
		end while (!resp_valid);
	endtask

	always @(posedge clk) begin
		if (!reset && resp_valid) begin
			if (exp_q.size() == 0) begin
				$display("Response pulse at %0t with no access outstanding", $time);
				stop_with_failure();
			end else begin
				got_exp = exp_q.pop_front();
				// Access still in flight while the response is out
				check_value(LINE_BITS'(req_ready), LINE_BITS'(0), "req_ready during response");
				if (got_exp.is_read)
					check_value(resp.rdata, got_exp.data, "read data");
				check_value(LINE_BITS'(resp.hit), LINE_BITS'(got_exp.hit), "hit flag");
				if (got_exp.hit) // Hits answer one cycle after the accept
					check_value(LINE_BITS'(cycle - got_exp.accept_cycle), LINE_BITS'(1),
						"hit latency");
			end
		end
	end

	initial begin : stimulus
		logic [31:0] addr;
		logic [31:0] line;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		init_reference();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Cold reads of one line per index
		do_access(32'h004, OP_READ, '0, '0);
		do_access(32'h018, OP_READ, '0, '0);
		do_access(32'h028, OP_READ, '0, '0);
		do_access(32'h03c, OP_READ, '0, '0);

		// Same line again
		do_access(32'h018, OP_READ, '0, '0);
		do_access(32'h018, OP_READ, '0, '0);

		for (int i = 0; i < 4; i++) begin
			addr = (i % 2 == 0) ? 32'h028 : 32'h03c;
			do_access(addr, OP_WRITE, 16'(rand_word()), random_line());
			do_access(addr, OP_READ, '0, '0);
		end

		// Three lines on index 1 with two ways
		for (int i = 0; i < 3; i++)
			do_access(32'h010 + 32'(i) * 32'h40, OP_WRITE, 16'(rand_word()), random_line());
		for (int i = 0; i < 3; i++)
			do_access(32'h010 + 32'(i) * 32'h40, OP_READ, '0, '0);

		$display("Random mix of 300 accesses");
		for (int n = 0; n < 300; n++) begin
			line = (rand_word() % 16) * 4 + (rand_word() % 2); // Indices 0 and 1
			addr = line * 16 + (rand_word() % 16);
			if (rand_word() % 2 == 0)
				do_access(addr, OP_READ, '0, '0);
			else
				do_access(addr, OP_WRITE, 16'(rand_word()), random_line());
		end

		wait_for_ready();
		if (exp_q.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("%0d responses never arrived", exp_q.size());
			stop_with_failure();
		end
	end

endmodule

//--- verilog/cache_system.sv
`timescale 1ns/10ps

module cache_system #(
	parameter int WAYS = 2,
	parameter int LINES = 4,
	parameter int MEM_LINES = 64,
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::cpu_resp_t resp
);
	import cache_pkg::*;

	localparam int IDX_W = $clog2(LINES);
	localparam int WAY_W = $clog2(WAYS);
	localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

	// Controller to ways
	logic [IDX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	logic [LINE_BYTES-1:0] byte_en;
	logic [LINE_BITS-1:0] wdata;
	logic [WAYS-1:0] wr_en;
	logic [WAYS-1:0] fill_en;
	logic [TAG_W-1:0] fill_tag;
	logic [LINE_BITS-1:0] fill_line;

	// Ways back to controller, packed per way
	logic [WAYS-1:0] way_hit;
	logic [WAYS-1:0] way_valid;
	logic [WAYS-1:0][LINE_BITS-1:0] way_line;
	logic [WAYS-1:0] way_dirty;
	logic [WAYS-1:0][TAG_W-1:0] way_tag;

	logic [WAY_W-1:0] victim;
	logic refill_done;

	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_ack;
	logic [LINE_BITS-1:0] mem_rdata;

	cache_ctrl #(.WAYS(WAYS), .LINES(LINES)) cache_ctrl_inst (
		.clk, .reset, .req_valid, .req, .req_ready, .resp_valid, .resp,
		.index, .tag, .byte_en, .wdata, .wr_en, .fill_en, .fill_tag, .fill_line,
		.way_hit, .way_valid, .way_line, .way_dirty, .way_tag,
		.victim, .refill_done,
		.mem_req_valid, .mem_req, .mem_ack, .mem_rdata
	);

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		cache_way #(.LINES(LINES)) cache_way_inst (
			.clk, .reset, .index, .tag,
			.wr_en(wr_en[w]), .byte_en, .wdata,
			.fill_en(fill_en[w]), .fill_tag, .fill_line,
			.hit(way_hit[w]), .valid(way_valid[w]), .rd_line(way_line[w]),
			.victim_dirty(way_dirty[w]), .victim_tag(way_tag[w])
		);
	end

	cache_replace #(.WAYS(WAYS), .LINES(LINES)) cache_replace_inst (
		.clk, .reset, .index, .way_valid, .refill_done, .victim
	);

	main_memory #(.MEM_LINES(MEM_LINES), .MEM_LATENCY(MEM_LATENCY)) main_memory_inst (
		.clk, .reset,
		.req_valid(mem_req_valid), .req(mem_req),
		.ack(mem_ack), .rdata(mem_rdata)
	);

endmodule

//--- verilog/main_memory.sv
`timescale 1ns/10ps

module main_memory #(
	parameter int MEM_LINES = 64,
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::mem_req_t req,
	output logic ack,
	output logic [cache_pkg::LINE_BITS-1:0] rdata
);
	import cache_pkg::*;

	localparam int LINE_AW = $clog2(MEM_LINES);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [LINE_BITS-1:0] mem [MEM_LINES];
	logic busy;
	logic [CNT_W-1:0] count; // Cycles since the request was seen
	logic [ADDR_W-OFFSET_W-1:0] line_addr;
	logic [LINE_AW-1:0] line;

	assign line_addr = req.addr[ADDR_W-1:OFFSET_W];
	assign line = LINE_AW'(line_addr % MEM_LINES); // Store wraps around

	// Each 32 bit word starts out holding its own byte address
	initial begin
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int w = 0; w < LINE_BITS / 32; w++)
				mem[l][32*w +: 32] = 32'(l * LINE_BYTES + w * 4);
		end
	end

	assign ack = busy && (count == CNT_W'(MEM_LATENCY));
	assign rdata = mem[line];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (ack) begin
			busy <= 1'b0;
			count <= '0;
		end else if (busy) begin
			count <= count + 1'b1;
		end else if (req_valid) begin
			busy <= 1'b1;
			count <= CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (ack && req.op == OP_WRITE)
			mem[line] <= req.wdata;
	end

	a_no_overlap: assert property (
		@(posedge clk) disable iff (reset) $rose(req_valid) |-> !busy
	) else $error("main_memory: new request while one is pending");

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
	parameter int WAYS = 2,
	parameter int LINES = 4,
	localparam int IDX_W = $clog2(LINES),
	localparam int WAY_W = $clog2(WAYS),
	localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input cache_pkg::cpu_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::cpu_resp_t resp,
	output logic [IDX_W-1:0] index,
	output logic [TAG_W-1:0] tag,
	output logic [cache_pkg::LINE_BYTES-1:0] byte_en,
	output logic [cache_pkg::LINE_BITS-1:0] wdata,
	output logic [WAYS-1:0] wr_en,
	output logic [WAYS-1:0] fill_en,
	output logic [TAG_W-1:0] fill_tag,
	output logic [cache_pkg::LINE_BITS-1:0] fill_line,
	input logic [WAYS-1:0] way_hit,
	input logic [WAYS-1:0] way_valid,
	input logic [WAYS-1:0][cache_pkg::LINE_BITS-1:0] way_line,
	input logic [WAYS-1:0] way_dirty,
	input logic [WAYS-1:0][TAG_W-1:0] way_tag,
	input logic [WAY_W-1:0] victim,
	output logic refill_done,
	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_ack,
	input logic [cache_pkg::LINE_BITS-1:0] mem_rdata
);
	import cache_pkg::*;

	ctrl_state_t state;
	cpu_req_t req_q;
	logic missed_q; // Access went to memory at least once
	logic [WAY_W-1:0] victim_q;
	logic any_hit;
	logic victim_dirty;
	logic [LINE_BITS-1:0] hit_line;

	// Held request fans out to every way
	assign index = req_q.addr[OFFSET_W +: IDX_W];
	assign tag = req_q.addr[ADDR_W-1 -: TAG_W];
	assign byte_en = req_q.byte_en;
	assign wdata = req_q.wdata;

	assign any_hit = |way_hit;
	assign victim_dirty = way_valid[victim] && way_dirty[victim];

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++)
			hit_line = hit_line | (way_line[w] & {LINE_BITS{way_hit[w]}});
	end

	assign req_ready = (state == ST_IDLE);
	assign resp_valid = (state == ST_LOOKUP) && any_hit;
	assign resp.rdata = hit_line; // Don't care for writes
	assign resp.hit = !missed_q;

	assign wr_en = (state == ST_LOOKUP && req_q.op == OP_WRITE) ? way_hit : '0;
	assign refill_done = (state == ST_REFILL) && mem_ack;
	assign fill_en = refill_done ? (WAYS'(1) << victim_q) : '0;
	assign fill_tag = tag;
	assign fill_line = mem_rdata;

	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			req_q <= req;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			missed_q <= 1'b0;
			mem_req_valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_LOOKUP;
						missed_q <= 1'b0;
					end
				end
				ST_LOOKUP: begin
					if (any_hit) begin
						state <= ST_IDLE;
					end else begin
						missed_q <= 1'b1;
						mem_req_valid <= 1'b1;
						state <= victim_dirty ? ST_WRITEBACK : ST_REFILL;
					end
				end
				ST_WRITEBACK: begin
					if (mem_ack) begin
						mem_req_valid <= 1'b0; // One idle cycle before the refill
						state <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (mem_ack) begin
						mem_req_valid <= 1'b0;
						state <= ST_LOOKUP; // Retry, now a hit
					end else if (!mem_req_valid) begin
						mem_req_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Memory request payload and the chosen victim
	always_ff @(posedge clk) begin
		if (state == ST_LOOKUP && !any_hit) begin
			victim_q <= victim;
			if (victim_dirty) begin
				mem_req.addr <= {way_tag[victim], index, {OFFSET_W{1'b0}}};
				mem_req.op <= OP_WRITE;
				mem_req.wdata <= way_line[victim];
			end else begin
				mem_req.addr <= {tag, index, {OFFSET_W{1'b0}}};
				mem_req.op <= OP_READ;
			end
		end else if (state == ST_WRITEBACK && mem_ack) begin
			mem_req.addr <= {tag, index, {OFFSET_W{1'b0}}};
			mem_req.op <= OP_READ;
		end
	end

	a_hit_onehot: assert property (
		@(posedge clk) disable iff (reset) state == ST_LOOKUP |-> $onehot0(way_hit)
	) else $error("cache_ctrl: more than one way hit");

	a_mem_req_stable: assert property (
		@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_ack |=> mem_req_valid && $stable(mem_req)
	) else $error("cache_ctrl: memory request changed before ack");

endmodule

//--- verilog/cache_replace.sv
`timescale 1ns/10ps

module cache_replace #(
	parameter int WAYS = 2,
	parameter int LINES = 4,
	localparam int IDX_W = $clog2(LINES),
	localparam int WAY_W = $clog2(WAYS)
) (
	input logic clk,
	input logic reset,
	input logic [IDX_W-1:0] index,
	input logic [WAYS-1:0] way_valid,
	input logic refill_done,
	output logic [WAY_W-1:0] victim
);

	logic [WAY_W-1:0] rr_ptr [LINES]; // One pointer per index

	// Lowest invalid way wins, else the round-robin pointer
	always_comb begin
		victim = rr_ptr[index];
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!way_valid[w])
				victim = WAY_W'(w);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LINES; i++)
				rr_ptr[i] <= '0;
		end else if (refill_done) begin
			if (rr_ptr[index] == WAY_W'(WAYS - 1))
				rr_ptr[index] <= '0; // Wrap for non power of two way counts
			else
				rr_ptr[index] <= rr_ptr[index] + 1'b1;
		end
	end

	a_victim_range: assert property (
		@(posedge clk) disable iff (reset) int'(victim) < WAYS
	) else $error("cache_replace: victim out of range");

endmodule

//--- verilog/cache_way.sv
`timescale 1ns/10ps

module cache_way #(
	parameter int LINES = 4,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W
) (
	input logic clk,
	input logic reset,
	input logic [IDX_W-1:0] index,
	input logic [TAG_W-1:0] tag,
	input logic wr_en,
	input logic [cache_pkg::LINE_BYTES-1:0] byte_en,
	input logic [cache_pkg::LINE_BITS-1:0] wdata,
	input logic fill_en,
	input logic [TAG_W-1:0] fill_tag,
	input logic [cache_pkg::LINE_BITS-1:0] fill_line,
	output logic hit,
	output logic valid,
	output logic [cache_pkg::LINE_BITS-1:0] rd_line,
	output logic victim_dirty,
	output logic [TAG_W-1:0] victim_tag
);
	import cache_pkg::*;

	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINE_BITS-1:0] line_mem [LINES];
	logic [LINE_BITS-1:0] merged;

	// Lookup is purely combinational on the held index and tag
	assign valid = valid_q[index];
	assign hit = valid_q[index] && (tag_mem[index] == tag);
	assign rd_line = line_mem[index];
	assign victim_dirty = dirty_q[index];
	assign victim_tag = tag_mem[index];

	// Only the enabled bytes take the new data
	always_comb begin
		merged = line_mem[index];
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (byte_en[b])
				merged[8*b +: 8] = wdata[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_en) begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= 1'b0; // Fresh copy of memory
		end else if (wr_en) begin
			dirty_q[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_mem[index] <= fill_tag;
			line_mem[index] <= fill_line;
		end else if (wr_en) begin
			line_mem[index] <= merged;
		end
	end

	// A refill and a hit write never land in the same cycle
	a_no_fill_and_write: assert property (
		@(posedge clk) disable iff (reset) !(wr_en && fill_en)
	) else $error("cache_way: write and fill in the same cycle");

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

	// Address and line geometry
	localparam int ADDR_W = 32;
	localparam int LINE_BITS = 128;
	localparam int LINE_BYTES = LINE_BITS / 8;
	localparam int OFFSET_W = $clog2(LINE_BYTES); // 4 for a 16 byte line

	typedef enum logic {
		OP_READ = 1'b0,
		OP_WRITE = 1'b1
	} op_t;

	// Access FSM of the controller
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_REFILL
	} ctrl_state_t;

	// Client request, data is line wide and byte_en picks the bytes
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		op_t op;
		logic [LINE_BYTES-1:0] byte_en;
		logic [LINE_BITS-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [LINE_BITS-1:0] rdata;
		logic hit; // No memory transaction was needed
	} cpu_resp_t;

	// Memory request, always a whole line
	typedef struct packed {
		logic [ADDR_W-1:0] addr; // Line aligned
		op_t op;
		logic [LINE_BITS-1:0] wdata;
	} mem_req_t;

endpackage
